// File: Bender.yml
package:
  name: botPermuter

sources:
  - common/botPermPkg.sv
  - botFifo/botFifoRam.sv
  - botFifo/botFifo.sv
  - permSelector/permSelector.sv
  - hdl/permuteNetwork.sv
  - hdl/botPermuter.sv
  - target: test
    files:
      - dv/botPermuterTb.sv

// File: botFifo/botFifo.sv
`default_nettype none

module botFifo import botPermPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 write,
    input  logic [botWidth-1:0]  botIn,
    input  logic [maskWidth-1:0] maskIn,
    input  logic                 lastIn,
    output logic                 almostFull,

    input  logic                 accept,
    output logic [maskWidth-1:0] nextMask,
    output logic                 nextLast,
    output logic [botWidth-1:0]  storedBot
);

    logic [fifoDepthLog2:0]   writePtr;  // Extra bit tells full from empty
    logic [fifoDepthLog2:0]   readPtr;
    logic [fifoDepthLog2:0]   used;
    logic [fifoDepthLog2:0]   freeSpace;
    logic                     empty;
    logic                     full;
    logic                     doWrite;
    logic                     pop;

    logic [fifoDepthLog2-1:0] headAddr;  // Entry now shown on nextMask
    logic [botReadDelay-1:0]  acceptPipe;
    logic [fifoDepthLog2-1:0] addrPipe [botReadDelay];
    logic [maskWidth:0]       maskWord;

    assign used      = writePtr - readPtr;
    assign freeSpace = {1'b1, {fifoDepthLog2{1'b0}}} - used;
    assign empty     = used == '0;
    assign full      = used[fifoDepthLog2];
    assign doWrite   = write && !full;
    assign pop       = accept && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr   <= '0;
            readPtr    <= '0;
            almostFull <= 1'b0;
            acceptPipe <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= readPtr + 1'b1;
            end
            almostFull <= freeSpace < almostFullMargin;
            acceptPipe <= {acceptPipe[botReadDelay-2:0], accept};
        end
    end

    // Address of the entry the selector takes on its next accept
    always_ff @(posedge clk) begin
        if (pop) begin
            headAddr <= readPtr[fifoDepthLog2-1:0];
        end
        addrPipe[0] <= headAddr;
        for (int i = 1; i < botReadDelay; i++) begin
            addrPipe[i] <= addrPipe[i-1];
        end
    end

    // An accept with nothing new clears the head, so a mask is never seen twice
    botFifoRam #(.dataT(logic [maskWidth:0])) maskRam (
        .clk        (clk),
        .writeEnable(doWrite),
        .writeAddr  (writePtr[fifoDepthLog2-1:0]),
        .dataIn     ({maskIn, lastIn}),
        .readEnable (accept),
        .readAddr   (readPtr[fifoDepthLog2-1:0]),
        .clearOut   (rst || (accept && empty)),
        .dataOut    (maskWord)
    );

    assign nextMask = maskWord[maskWidth:1];
    assign nextLast = maskWord[0];

    // Bot lands together with the first selection of its entry
    botFifoRam #(.dataT(logic [botWidth-1:0])) botRam (
        .clk        (clk),
        .writeEnable(doWrite),
        .writeAddr  (writePtr[fifoDepthLog2-1:0]),
        .dataIn     (botIn),
        .readEnable (acceptPipe[botReadDelay-1]),
        .readAddr   (addrPipe[botReadDelay-1]),
        .clearOut   (1'b0),
        .dataOut    (storedBot)
    );

    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst) full |-> !write)
        else $error("botFifo written while full");

endmodule

`default_nettype wire

// File: botFifo/botFifoRam.sv
`default_nettype none

module botFifoRam import botPermPkg::*; #(
    parameter type dataT = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     writeEnable,
    input  logic [fifoDepthLog2-1:0] writeAddr,
    input  dataT                     dataIn,
    input  logic                     readEnable,
    input  logic [fifoDepthLog2-1:0] readAddr,
    input  logic                     clearOut,
    output dataT                     dataOut
);

    dataT mem [2**fifoDepthLog2];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
    end

    // Registered read port, clear wins over a read
    always_ff @(posedge clk) begin
        if (clearOut) begin
            dataOut <= '0;
        end else if (readEnable) begin
            dataOut <= mem[readAddr];
        end
    end

endmodule

`default_nettype wire

// File: botPermuter.f
common/botPermPkg.sv
botFifo/botFifoRam.sv
botFifo/botFifo.sv
permSelector/permSelector.sv
hdl/permuteNetwork.sv
hdl/botPermuter.sv
dv/botPermuterTb.sv

// File: common/botPermPkg.sv
`default_nettype none

package botPermPkg;

    // Bot geometry
    localparam int botWidth    = 128;
    localparam int byteWidth   = 8;
    localparam int numMinterms = 16;

    // Variable orders are grouped in sets by the variable placed first
    localparam int numSets     = 4;  // Set 0 puts d first, set 3 puts a first
    localparam int permsPerSet = 6;
    localparam int maskWidth   = numSets * permsPerSet;  // Bit set*6 + perm

    // FIFO sizing
    localparam int fifoDepthLog2    = 6;
    localparam int almostFullMargin = 8;  // Free entries below which almostFull rises
    localparam int botReadDelay     = 2;  // Bot read lags the mask read by this much

    // Order names, four ASCII letters each, letter 0 in the top byte.
    // The letter in place k is the input variable whose index bit becomes
    // output index bit k. Listed from set 3 down to set 0, and within a set
    // from perm 5 down to perm 0.
    localparam logic [numSets-1:0][permsPerSet-1:0][31:0] varOrderTable = {
        "abcd", "abdc", "acbd", "acdb", "adbc", "adcb",  // Set 3
        "bacd", "badc", "bcad", "bcda", "bdac", "bdca",  // Set 2
        "cbad", "cbda", "cabd", "cadb", "cdba", "cdab",  // Set 1
        "dbca", "dbac", "dcba", "dcab", "dabc", "dacb"   // Set 0
    };

endpackage

`default_nettype wire

// File: dv/botPermuterTb.sv
`default_nettype none

module botPermuterTb import botPermPkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 write;
    logic [botWidth-1:0]  botIn;
    logic [maskWidth-1:0] maskIn;
    logic                 lastIn;
    logic                 almostFull;
    logic                 slowDown;
    logic                 valid;
    logic [botWidth-1:0]  permutedBot;
    logic                 batchDone;

    // Stimulus table, one row per bot
    string                rowName [$];
    logic [botWidth-1:0]  rowBot [$];
    logic [maskWidth-1:0] rowMask [$];
    logic                 rowLast [$];
    logic [7:0]           rowPat [$];  // slowDown pattern, one bit per cycle

    // Expected results in output order
    string                expName [$];
    logic [botWidth-1:0]  expBot [$];
    logic                 expDone [$];
    logic                 expValid [$];  // Low for a lone batchDone

    integer     seed;
    int         fillStart;
    int         cycles = 0;
    int         cycleLimit = 32'h7fff_ffff;
    logic [7:0] curPat = 8'h00;
    int         patPos = 0;
    logic [1:0] slowHist = 2'b00;

    string orderTable [4][6] = '{
        '{"dacb", "dabc", "dcab", "dcba", "dbac", "dbca"},
        '{"cdab", "cdba", "cadb", "cabd", "cbda", "cbad"},
        '{"bdca", "bdac", "bcda", "bcad", "badc", "bacd"},
        '{"adcb", "adbc", "acdb", "acbd", "abdc", "abcd"}
    };

    botPermuter i_dut (
        .clk        (clk),
        .rst        (rst),
        .write      (write),
        .botIn      (botIn),
        .maskIn     (maskIn),
        .lastIn     (lastIn),
        .almostFull (almostFull),
        .slowDown   (slowDown),
        .valid      (valid),
        .permutedBot(permutedBot),
        .batchDone  (batchDone)
    );

    always #10 clk = !clk;

    // Output byte m takes the input byte whose variable bits are routed from m
    function automatic logic [botWidth-1:0] permuteRef(input logic [botWidth-1:0] b,
                                                       input int set, input int perm);
        string                name;
        int                   src;
        int                   v;
        logic [botWidth-1:0]  r;
        name = orderTable[set][perm];
        for (int m = 0; m < numMinterms; m++) begin
            src = 0;
            for (int k = 0; k < 4; k++) begin
                v = name[k] - "a";
                if (m[k]) src |= 1 << v;
            end
            r[m*byteWidth +: byteWidth] = b[src*byteWidth +: byteWidth];
        end
        return r;
    endfunction

    function automatic logic [botWidth-1:0] randomBot();
        logic [botWidth-1:0] b;
        for (int w = 0; w < 4; w++) begin
            b[w*32 +: 32] = $random(seed);
        end
        return b;
    endfunction

    task automatic addRow(input string name, input logic [maskWidth-1:0] mask,
                          input logic last, input logic [7:0] pat);
        rowName.push_back(name);
        rowBot.push_back(randomBot());
        rowMask.push_back(mask);
        rowLast.push_back(last);
        rowPat.push_back(pat);
    endtask

    task automatic stopOnError();
        $display("Errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkBot(input string name, input logic [botWidth-1:0] expected,
                            input logic [botWidth-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", name, expected, actual);
            stopOnError();
        end
    endtask

    // Expand one row into its expected outputs, perm ascending then set ascending
    task automatic expectRow(input int i);
        int count;
        int seen;
        count = $countones(rowMask[i]);
        seen = 0;
        if (count == 0 && rowLast[i]) begin
            expName.push_back({rowName[i], " empty last"});
            expBot.push_back('0);
            expDone.push_back(1'b1);
            expValid.push_back(1'b0);
        end
        for (int p = 0; p < permsPerSet; p++) begin
            for (int s = 0; s < numSets; s++) begin
                if (rowMask[i][s*permsPerSet + p]) begin
                    seen++;
                    expName.push_back($sformatf("%s order %s", rowName[i], orderTable[s][p]));
                    expBot.push_back(permuteRef(rowBot[i], s, p));
                    expDone.push_back(rowLast[i] && seen == count);
                    expValid.push_back(1'b1);
                end
            end
        end
    endtask

    task automatic waitDrain();
        while (expName.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            slowDown = 1'b0;
        end else begin
            slowDown = curPat[patPos];
            patPos = (patPos + 1) % 8;
        end
    end

    always @(posedge clk) begin
        slowHist <= {slowHist[0], slowDown};
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run took too long, outputs stopped arriving");
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // Output checker
    always @(negedge clk) begin
        if (!rst && (valid || batchDone)) begin
            if (expName.size() == 0) begin
                $display("An output appeared when none was expected");
                stopOnError();
            end
            checkBit({expName[0], " valid"}, expValid[0], valid);
            if (valid) checkBot(expName[0], expBot[0], permutedBot);
            checkBit({expName[0], " batchDone"}, expDone[0], batchDone);
            void'(expName.pop_front());
            void'(expBot.pop_front());
            void'(expDone.pop_front());
            void'(expValid.pop_front());
        end
        if (!rst && slowHist[1] && valid) begin
            $display("valid was high right after a slowDown cycle");
            stopOnError();
        end
    end

    initial begin
        seed = 32'hcbdc_f6e3;
        rst = 1'b1;
        write = 1'b0;
        botIn = '0;
        maskIn = '0;
        lastIn = 1'b0;
        slowDown = 1'b0;

        for (int s = 0; s < numSets; s++) begin
            for (int p = 0; p < permsPerSet; p++) begin
                addRow($sformatf("single s%0d p%0d", s, p), 24'(1) << (s*permsPerSet + p),
                       1'b0, 8'h00);
            end
        end
        addRow("full mask", '1, 1'b1, 8'h00);
        for (int i = 0; i < 32; i++) begin
            // Sparse masks, about three bits each
            addRow($sformatf("random %0d", i), 24'($random(seed) & $random(seed) & $random(seed)),
                   (i % 5) == 4, (i < 16) ? 8'h00 : 8'($random(seed)));
        end
        addRow("zero mask", '0, 1'b0, 8'h00);
        addRow("zero last", '0, 1'b1, 8'h00);
        addRow("after zero", 24'h000041, 1'b1, 8'h00);
        fillStart = rowName.size();
        for (int i = 0; i < 60; i++) begin
            addRow($sformatf("fill %0d", i), 24'(1) << (i % maskWidth), i == 59, 8'hff);
        end
        cycleLimit = rowName.size() * 30 + 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rowName.size(); i++) begin
            if (i == fillStart) begin
                @(negedge clk);
                write = 1'b0;
                waitDrain();
                curPat <= 8'hff;  // Selector stalls while the FIFO fills
                @(negedge clk);
            end
            @(negedge clk);
            if (i == fillStart + 50) checkBit("almostFull at 50 entries", 1'b0, almostFull);
            while (i < fillStart && almostFull) begin
                write = 1'b0;
                @(negedge clk);
            end
            write = 1'b1;
            botIn = rowBot[i];
            maskIn = rowMask[i];
            lastIn = rowLast[i];
            if (i < fillStart) curPat <= rowPat[i];
            expectRow(i);
        end
        @(negedge clk);
        write = 1'b0;

        repeat (3) @(negedge clk);
        checkBit("almostFull at 60 entries", 1'b1, almostFull);
        curPat <= 8'h00;
        waitDrain();
        checkBit("almostFull after drain", 1'b0, almostFull);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/botPermuter.sv
`default_nettype none

module botPermuter import botPermPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 write,
    input  logic [botWidth-1:0]  botIn,
    input  logic [maskWidth-1:0] maskIn,
    input  logic                 lastIn,
    output logic                 almostFull,

    input  logic                 slowDown,
    output logic                 valid,
    output logic [botWidth-1:0]  permutedBot,
    output logic                 batchDone
);

    logic                 accept;
    logic [maskWidth-1:0] nextMask;
    logic                 nextLast;
    logic [botWidth-1:0]  storedBot;

    logic                 selValid;
    logic [1:0]           selSet;
    logic [2:0]           selPerm;
    logic                 selBatchDone;

    botFifo fifo (
        .clk       (clk),
        .rst       (rst),
        .write     (write),
        .botIn     (botIn),
        .maskIn    (maskIn),
        .lastIn    (lastIn),
        .almostFull(almostFull),
        .accept    (accept),
        .nextMask  (nextMask),
        .nextLast  (nextLast),
        .storedBot (storedBot)
    );

    permSelector selector (
        .clk         (clk),
        .rst         (rst),
        .nextMask    (nextMask),
        .nextLast    (nextLast),
        .accept      (accept),
        .slowDown    (slowDown),
        .selValid    (selValid),
        .selSet      (selSet),
        .selPerm     (selPerm),
        .selBatchDone(selBatchDone)
    );

    permuteNetwork network (
        .clk        (clk),
        .selSet     (selSet),
        .selPerm    (selPerm),
        .storedBot  (storedBot),
        .permutedBot(permutedBot)
    );

    // Network decode adds one cycle, flags follow it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= 1'b0;
            batchDone <= 1'b0;
        end else begin
            valid     <= selValid;
            batchDone <= selBatchDone;
        end
    end

endmodule

`default_nettype wire

// File: hdl/permuteNetwork.sv
`default_nettype none

module permuteNetwork import botPermPkg::*; (
    input  logic                clk,
    input  logic [1:0]          selSet,
    input  logic [2:0]          selPerm,
    input  logic [botWidth-1:0] storedBot,
    output logic [botWidth-1:0] permutedBot
);

    // Input variable behind output index bit k of an order name
    function automatic logic [1:0] sourceVar(input logic [31:0] name, input int place);
        logic [7:0] letter;
        letter = name[31 - 8*place -: 8];
        return 2'(letter - "a");
    endfunction

    // Codes 0 to 5 stand for pairs {0,1} {0,2} {0,3} {1,2} {1,3} {2,3}
    function automatic logic [2:0] pairCode(input logic [1:0] x, input logic [1:0] y);
        logic [1:0] lo;
        logic [1:0] hi;
        lo = (x < y) ? x : y;
        hi = (x < y) ? y : x;
        case (lo)
            2'd0:    return 3'(hi) - 3'd1;
            2'd1:    return 3'(hi) + 3'd1;
            default: return 3'd5;
        endcase
    endfunction

    logic [31:0] orderName;
    logic [1:0]  src [4];
    logic [1:0]  srcPosA, srcPosB, srcPosC, srcPosD;
    logic [2:0]  srcPosAB, srcPosAC, srcPosAD;

    always_comb begin
        orderName = varOrderTable[selSet][0];
        if (selPerm < permsPerSet) begin
            orderName = varOrderTable[selSet][selPerm];
        end
        for (int k = 0; k < 4; k++) begin
            src[k] = sourceVar(orderName, k);
        end
    end

    always_ff @(posedge clk) begin
        srcPosA  <= src[0];
        srcPosB  <= src[1];
        srcPosC  <= src[2];
        srcPosD  <= src[3];
        srcPosAB <= pairCode(src[0], src[1]);
        srcPosAC <= pairCode(src[0], src[2]);
        srcPosAD <= pairCode(src[0], src[3]);
    end

    logic [numMinterms-1:0][byteWidth-1:0] inByte;
    logic [numMinterms-1:0][byteWidth-1:0] outByte;
    logic [3:0][byteWidth-1:0]             oneHot;     // Index with one bit set
    logic [3:0][byteWidth-1:0]             oneCold;    // Index with one bit clear
    logic [5:0][byteWidth-1:0]             pairBytes;
    logic [5:0][byteWidth-1:0]             pairCompl;  // Complement of each pair

    assign inByte    = storedBot;
    assign oneHot    = {inByte[8], inByte[4], inByte[2], inByte[1]};
    assign oneCold   = {inByte[7], inByte[11], inByte[13], inByte[14]};
    assign pairBytes = {inByte[12], inByte[10], inByte[6], inByte[9], inByte[5], inByte[3]};
    assign pairCompl = {inByte[3], inByte[5], inByte[9], inByte[6], inByte[10], inByte[12]};

    assign outByte[0]  = inByte[0];
    assign outByte[15] = inByte[15];

    assign outByte[1]  = oneHot[srcPosA];
    assign outByte[2]  = oneHot[srcPosB];
    assign outByte[4]  = oneHot[srcPosC];
    assign outByte[8]  = oneHot[srcPosD];
    assign outByte[14] = oneCold[srcPosA];
    assign outByte[13] = oneCold[srcPosB];
    assign outByte[11] = oneCold[srcPosC];
    assign outByte[7]  = oneCold[srcPosD];

    assign outByte[3]  = pairBytes[srcPosAB];
    assign outByte[5]  = pairBytes[srcPosAC];
    assign outByte[9]  = pairBytes[srcPosAD];
    assign outByte[12] = pairCompl[srcPosAB];  // Places c and d hold the other two
    assign outByte[10] = pairCompl[srcPosAC];
    assign outByte[6]  = pairCompl[srcPosAD];

    assign permutedBot = outByte;

endmodule

`default_nettype wire

// File: permSelector/permSelector.sv
`default_nettype none

module permSelector import botPermPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [maskWidth-1:0] nextMask,
    input  logic                 nextLast,
    output logic                 accept,

    input  logic                 slowDown,
    output logic                 selValid,
    output logic [1:0]           selSet,
    output logic [2:0]           selPerm,
    output logic                 selBatchDone
);

    logic [numSets-1:0]   sections [permsPerSet];  // One per perm, bit s is set s
    logic                 storedLast;
    logic [maskWidth-1:0] pending;
    logic                 allZero;
    logic                 oneBitLeft;
    logic                 finishing;
    logic [2:0]           pickPerm;
    logic [1:0]           pickSet;

    // Flat view of what is still to be sent
    always_comb begin
        for (int p = 0; p < permsPerSet; p++) begin
            pending[p*numSets +: numSets] = sections[p];
        end
    end

    assign allZero    = pending == '0;
    assign oneBitLeft = !allZero && ((pending & (pending - 1'b1)) == '0);

    // Lowest non-empty section, then the lowest set inside it
    always_comb begin
        pickPerm = '0;
        for (int p = permsPerSet - 1; p >= 0; p--) begin
            if (sections[p] != '0) begin
                pickPerm = 3'(p);
            end
        end
        pickSet = '0;
        for (int s = numSets - 1; s >= 0; s--) begin
            if (sections[pickPerm][s]) begin
                pickSet = 2'(s);
            end
        end
    end

    // Next mask is taken early while the last bit goes out, except at batch end
    assign accept = ((oneBitLeft && !storedLast) || allZero) && !slowDown;

    // Final selection of a last bot, or moving past a last bot with no bits
    assign finishing = storedLast && (oneBitLeft || allZero) && !slowDown;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < permsPerSet; p++) begin
                sections[p] <= '0;
            end
            storedLast   <= 1'b0;
            selValid     <= 1'b0;
            selBatchDone <= 1'b0;
        end else begin
            selValid     <= !allZero && !slowDown;
            selBatchDone <= finishing;
            if (accept) begin
                for (int p = 0; p < permsPerSet; p++) begin
                    for (int s = 0; s < numSets; s++) begin
                        sections[p][s] <= nextMask[s*permsPerSet + p];
                    end
                end
                storedLast <= nextLast;
            end else if (!slowDown && !allZero) begin
                sections[pickPerm] <= sections[pickPerm] & (sections[pickPerm] - 1'b1);
                storedLast <= storedLast && !oneBitLeft;  // Batch end already flagged
            end
        end
    end

    always_ff @(posedge clk) begin
        selSet  <= pickSet;
        selPerm <= pickPerm;
    end

    // A pick always lands on a bit that is still pending
    pickIsPending: assert property (@(posedge clk) disable iff (rst)
        !allZero |-> (pickPerm < permsPerSet) && sections[pickPerm][pickSet])
        else $error("selection names a mask bit that is not pending");

endmodule

`default_nettype wire
